/* files.f */
hdl/bf_pkg.sv
hdl/bf_cmd_ctrl.sv
hdl/bf_hash.sv
hdl/bf_bit_bank.sv
hdl/bf_code_match.sv
hdl/bf_verdict_pipe.sv
hdl/bf_top.sv
tests/tb_bf_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_bf_top -f files.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "$out" | grep -q "Simulation finished: PASS" || exit 1
exit 0

/* tests/tb_bf_top.sv */
module tb_bf_top;
    import bf_pkg::*;

    localparam int CYCLE_LIMIT = 3000;
    localparam int POOL_N = 16;

    logic      clk;
    logic      rst_n;
    logic      csr_req;
    cmd_word_t csr_data;
    logic      csr_ack;
    logic      arvalid;
    id_t       arid;
    addr_t     addr_ar;
    logic      awvalid;
    id_t       awid;
    addr_t     addr_aw;
    logic      arvalid_bf;
    id_t       arid_bf;
    logic      awvalid_bf;
    id_t       awid_bf;
    logic      ar_is_faulty;
    logic      aw_is_faulty;

    bf_top dut (.*);

    // reference model state
    logic     bank0_m [FILTER_SIZE];
    logic     bank1_m [FILTER_SIZE];
    bf_mode_e mode_m;
    addr_t    mask_m;
    addr_t    code_m;
    addr_t    pool [POOL_N];

    // expected outputs, index 2 is the entry due this cycle
    logic  e_live [3];
    logic  e_chk [3];
    logic  e_arv [3];
    logic  e_awv [3];
    id_t   e_arid [3];
    id_t   e_awid [3];
    logic  e_arf [3];
    logic  e_awf [3];
    string e_name [3];

    string       cur_test;
    logic [31:0] seed;
    int          cycles;
    int          val_errors;
    int          hs_errors;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic addr_t rand_addr();
        logic [31:0] r;
        r = next_rand();
        return r[26:0];
    endfunction

    function automatic addr_t pick_pool();
        logic [31:0] r;
        r = next_rand();
        return pool[r[11:8]];
    endfunction

    function automatic bank_addr_t hash0_of(input addr_t k);
        logic [31:0] x;
        x = {5'd0, k};
        x = x ^ (x >> 13);
        x = x ^ (x >> 7);
        return x[9:0];
    endfunction

    function automatic bank_addr_t hash1_of(input addr_t k);
        logic [31:0] x;
        x = {5'd0, k};
        x = (x ^ 32'h811c9dc5) ^ (x >> 11);
        x = x ^ (x >> 3);
        return x[9:0];
    endfunction

    // one cycle of request traffic, plus the expected result two cycles on
    task automatic step(input addr_t a_ar, input addr_t a_aw, input logic chk);
        logic [31:0] r;
        logic        hit_ar;
        logic        hit_aw;
        logic        cm;
        @(posedge clk);
        #1;
        r = next_rand();
        arvalid = r[3];
        awvalid = r[9];
        arid    = r[23:16];
        awid    = r[31:24];
        addr_ar = a_ar;
        addr_aw = a_aw;
        hit_ar  = bank0_m[hash0_of(a_ar)] && bank1_m[hash1_of(a_ar)];
        hit_aw  = bank0_m[hash0_of(a_aw)] && bank1_m[hash1_of(a_aw)];
        cm      = ((a_ar & mask_m) == (code_m & mask_m));
        for (int i = 2; i > 0; i--) begin
            e_live[i] = e_live[i-1];
            e_chk[i]  = e_chk[i-1];
            e_arv[i]  = e_arv[i-1];
            e_awv[i]  = e_awv[i-1];
            e_arid[i] = e_arid[i-1];
            e_awid[i] = e_awid[i-1];
            e_arf[i]  = e_arf[i-1];
            e_awf[i]  = e_awf[i-1];
            e_name[i] = e_name[i-1];
        end
        e_live[0] = 1'b1;
        e_chk[0]  = chk;
        e_arv[0]  = arvalid;
        e_awv[0]  = awvalid;
        e_arid[0] = arid;
        e_awid[0] = awid;
        e_arf[0]  = arvalid && (((mode_m == MODE_QUERY) && hit_ar)
                                || ((mode_m == MODE_CODE_MATCH) && cm));
        e_awf[0]  = awvalid && hit_aw
                    && ((mode_m == MODE_QUERY) || (mode_m == MODE_CODE_MATCH));
        e_name[0] = cur_test;
    endtask

    task automatic update_model(input cmd_word_t w);
        case (w)
            CMD_IDLE:       mode_m = MODE_IDLE;
            CMD_INSERT:     mode_m = MODE_INSERT;
            CMD_REMOVE:     mode_m = MODE_REMOVE;
            CMD_QUERY:      mode_m = MODE_QUERY;
            CMD_CODE_LOAD:  mode_m = MODE_CODE_LOAD;
            CMD_CODE_MATCH: mode_m = MODE_CODE_MATCH;
            default: begin
                if (mode_m == MODE_INSERT || mode_m == MODE_REMOVE) begin
                    bank0_m[hash0_of(w[26:0])] = (mode_m == MODE_INSERT);
                    bank1_m[hash1_of(w[26:0])] = (mode_m == MODE_INSERT);
                end else if (mode_m == MODE_CODE_LOAD && w[63:59] == 5'b01010
                             && w[4:0] == 5'b10101) begin
                    mask_m = w[58:32];
                    code_m = w[31:5];
                end
            end
        endcase
    endtask

    // four-phase transaction, faulty checks off while it settles
    task automatic send_cmd(input cmd_word_t w);
        logic [31:0] r;
        r = next_rand();
        step(rand_addr(), rand_addr(), 1'b0);
        assert (csr_ack == 1'b0) else begin
            hs_errors++;
            $display("handshake: ack was already high before req was raised");
        end
        csr_req  = 1'b1;
        csr_data = w;
        step(rand_addr(), rand_addr(), 1'b0);
        assert (csr_ack == 1'b1) else begin
            hs_errors++;
            $display("handshake: ack did not rise one cycle after req");
        end
        // host may hold req a few cycles longer
        for (int i = 0; i < int'(r[13:12]); i++) begin
            step(rand_addr(), rand_addr(), 1'b0);
            assert (csr_ack == 1'b1) else begin
                hs_errors++;
                $display("handshake: ack dropped while req was still high");
            end
        end
        csr_req = 1'b0;
        step(rand_addr(), rand_addr(), 1'b0);
        assert (csr_ack == 1'b0) else begin
            hs_errors++;
            $display("handshake: ack did not fall one cycle after req dropped");
        end
        update_model(w);
    endtask

    task automatic run_pool(input int n);
        for (int i = 0; i < n; i++) begin
            step(pick_pool(), pick_pool(), 1'b1);
        end
    endtask

    // half the read addresses are forced onto the loaded code
    task automatic run_code(input int n);
        logic [31:0] r;
        addr_t       a;
        for (int i = 0; i < n; i++) begin
            r = next_rand();
            a = rand_addr();
            if (r[5]) begin
                a = (code_m & mask_m) | (a & ~mask_m);
            end
            step(a, pick_pool(), 1'b1);
        end
    endtask

    ap_arvalid: assert property (@(negedge clk) disable iff (!rst_n)
        !e_live[2] || arvalid_bf == e_arv[2]) else begin
        val_errors++;
        $display("ERR %s arvalid_bf exp %0b act %0b", e_name[2], e_arv[2], arvalid_bf);
    end

    ap_awvalid: assert property (@(negedge clk) disable iff (!rst_n)
        !e_live[2] || awvalid_bf == e_awv[2]) else begin
        val_errors++;
        $display("ERR %s awvalid_bf exp %0b act %0b", e_name[2], e_awv[2], awvalid_bf);
    end

    ap_arid: assert property (@(negedge clk) disable iff (!rst_n)
        !(e_live[2] && e_arv[2]) || arid_bf == e_arid[2]) else begin
        val_errors++;
        $display("ERR %s arid_bf exp %h act %h", e_name[2], e_arid[2], arid_bf);
    end

    ap_awid: assert property (@(negedge clk) disable iff (!rst_n)
        !(e_live[2] && e_awv[2]) || awid_bf == e_awid[2]) else begin
        val_errors++;
        $display("ERR %s awid_bf exp %h act %h", e_name[2], e_awid[2], awid_bf);
    end

    ap_ar_faulty: assert property (@(negedge clk) disable iff (!rst_n)
        !(e_live[2] && e_chk[2]) || ar_is_faulty == e_arf[2]) else begin
        val_errors++;
        $display("ERR %s ar_is_faulty exp %0b act %0b", e_name[2], e_arf[2], ar_is_faulty);
    end

    ap_aw_faulty: assert property (@(negedge clk) disable iff (!rst_n)
        !(e_live[2] && e_chk[2]) || aw_is_faulty == e_awf[2]) else begin
        val_errors++;
        $display("ERR %s aw_is_faulty exp %0b act %0b", e_name[2], e_awf[2], aw_is_faulty);
    end

    initial begin
        seed       = 32'hab71b72b;
        cycles     = 0;
        val_errors = 0;
        hs_errors  = 0;
        cur_test   = "reset";
        rst_n      = 1'b0;
        csr_req    = 1'b0;
        csr_data   = '0;
        arvalid    = 1'b0;
        arid       = '0;
        addr_ar    = '0;
        awvalid    = 1'b0;
        awid       = '0;
        addr_aw    = '0;
        mode_m     = MODE_IDLE;
        mask_m     = '0;
        code_m     = '0;
        for (int i = 0; i < FILTER_SIZE; i++) begin
            bank0_m[i] = 1'b0;
            bank1_m[i] = 1'b0;
        end
        for (int i = 0; i < 3; i++) begin
            e_live[i] = 1'b0;
            e_chk[i]  = 1'b0;
        end
        for (int i = 0; i < POOL_N; i++) begin
            pool[i] = rand_addr();
        end

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (csr_ack == 1'b0 && arvalid_bf == 1'b0 && awvalid_bf == 1'b0) else begin
            hs_errors++;
            $display("reset: ack or a valid output was high after reset");
        end

        // clear every key the tests touch
        cur_test = "clear";
        send_cmd(CMD_REMOVE);
        for (int i = 0; i < POOL_N; i++) begin
            send_cmd({37'd0, pool[i]});
        end

        cur_test = "insert";
        send_cmd(CMD_INSERT);
        for (int i = 0; i < POOL_N / 2; i++) begin
            send_cmd({37'd0, pool[i]});
        end

        cur_test = "query";
        send_cmd(CMD_QUERY);
        run_pool(200);

        cur_test = "remove";
        send_cmd(CMD_REMOVE);
        for (int i = 0; i < 4; i++) begin
            send_cmd({37'd0, pool[i]});
        end
        send_cmd(CMD_QUERY);
        run_pool(150);

        cur_test = "code_match";
        send_cmd(CMD_CODE_LOAD);
        send_cmd({5'b01010, rand_addr() | 27'h0f0f00f, rand_addr(), 5'b10101});
        send_cmd(CMD_CODE_MATCH);
        run_code(200);

        // one marker broken in each word, old code must stay
        cur_test = "code_unframed";
        send_cmd(CMD_CODE_LOAD);
        send_cmd({5'b01011, rand_addr(), rand_addr(), 5'b10101});
        send_cmd({5'b01010, rand_addr(), rand_addr(), 5'b10100});
        send_cmd(CMD_CODE_MATCH);
        run_code(100);

        cur_test = "idle_modes";
        send_cmd(CMD_IDLE);
        run_pool(100);
        send_cmd(CMD_INSERT);
        run_pool(100);
        send_cmd(CMD_CODE_LOAD);
        run_code(100);

        repeat (3) step(rand_addr(), rand_addr(), 1'b1);
        @(posedge clk);

        $display("errors: value %0d, handshake %0d, total %0d",
                 val_errors, hs_errors, val_errors + hs_errors);
        if (val_errors + hs_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/bf_top.sv */
module bf_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              csr_req,
    input  bf_pkg::cmd_word_t csr_data,
    output logic              csr_ack,
    input  logic              arvalid,
    input  bf_pkg::id_t       arid,
    input  bf_pkg::addr_t     addr_ar,
    input  logic              awvalid,
    input  bf_pkg::id_t       awid,
    input  bf_pkg::addr_t     addr_aw,
    output logic              arvalid_bf,
    output bf_pkg::id_t       arid_bf,
    output logic              awvalid_bf,
    output bf_pkg::id_t       awid_bf,
    output logic              ar_is_faulty,
    output logic              aw_is_faulty
);
    import bf_pkg::*;

    bf_mode_e   mode;
    logic       wr_en;
    logic       wr_bit;
    addr_t      wr_key;
    logic       code_load;
    cmd_word_t  code_word;
    logic       ar_code_match;

    // per bank hash outputs, index = bank
    bank_addr_t wr_h [NUM_BANKS];
    bank_addr_t ar_h [NUM_BANKS];
    bank_addr_t aw_h [NUM_BANKS];
    logic [NUM_BANKS-1:0] ar_hit;
    logic [NUM_BANKS-1:0] aw_hit;

    bf_cmd_ctrl u_cmd_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_req   (csr_req),
        .csr_data  (csr_data),
        .csr_ack   (csr_ack),
        .mode      (mode),
        .wr_en     (wr_en),
        .wr_bit    (wr_bit),
        .wr_key    (wr_key),
        .code_load (code_load),
        .code_word (code_word)
    );

    bf_hash u_hash_wr (
        .key (wr_key),
        .h0  (wr_h[0]),
        .h1  (wr_h[1])
    );

    // raw request addresses, so bank data lines up with stage 2
    bf_hash u_hash_ar (
        .key (addr_ar),
        .h0  (ar_h[0]),
        .h1  (ar_h[1])
    );

    bf_hash u_hash_aw (
        .key (addr_aw),
        .h0  (aw_h[0]),
        .h1  (aw_h[1])
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
        bf_bit_bank u_bank (
            .clk       (clk),
            .wr_en     (wr_en),
            .wr_bit    (wr_bit),
            .wr_addr   (wr_h[i]),
            .rd_addr_a (ar_h[i]),
            .rd_addr_b (aw_h[i]),
            .q_a       (ar_hit[i]),
            .q_b       (aw_hit[i])
        );
    end

    bf_code_match u_code_match (
        .clk       (clk),
        .rst_n     (rst_n),
        .code_load (code_load),
        .code_word (code_word),
        .addr      (addr_ar),
        .match     (ar_code_match)
    );

    bf_verdict_pipe u_verdict (
        .clk           (clk),
        .rst_n         (rst_n),
        .mode          (mode),
        .arvalid       (arvalid),
        .awvalid       (awvalid),
        .arid          (arid),
        .awid          (awid),
        .ar_code_match (ar_code_match),
        .ar_hit0       (ar_hit[0]),
        .ar_hit1       (ar_hit[1]),
        .aw_hit0       (aw_hit[0]),
        .aw_hit1       (aw_hit[1]),
        .arvalid_bf    (arvalid_bf),
        .awvalid_bf    (awvalid_bf),
        .arid_bf       (arid_bf),
        .awid_bf       (awid_bf),
        .ar_is_faulty  (ar_is_faulty),
        .aw_is_faulty  (aw_is_faulty)
    );

endmodule

/* hdl/bf_verdict_pipe.sv */
module bf_verdict_pipe (
    input  logic             clk,
    input  logic             rst_n,
    input  bf_pkg::bf_mode_e mode,
    input  logic             arvalid,
    input  logic             awvalid,
    input  bf_pkg::id_t      arid,
    input  bf_pkg::id_t      awid,
    input  logic             ar_code_match,
    input  logic             ar_hit0,
    input  logic             ar_hit1,
    input  logic             aw_hit0,
    input  logic             aw_hit1,
    output logic             arvalid_bf,
    output logic             awvalid_bf,
    output bf_pkg::id_t      arid_bf,
    output bf_pkg::id_t      awid_bf,
    output logic             ar_is_faulty,
    output logic             aw_is_faulty
);
    import bf_pkg::*;

    logic     arvalid_s1;
    logic     awvalid_s1;
    id_t      arid_s1;
    id_t      awid_s1;
    bf_mode_e mode_s1;
    bf_mode_e mode_s2;
    logic     ar_match_s1;
    logic     ar_match_s2;
    logic     ar_hit_s2;
    logic     aw_hit_s2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arvalid_s1 <= 1'b0;
            awvalid_s1 <= 1'b0;
            arvalid_bf <= 1'b0;
            awvalid_bf <= 1'b0;
            mode_s1    <= MODE_IDLE;
            mode_s2    <= MODE_IDLE;
        end else begin
            arvalid_s1 <= arvalid;
            awvalid_s1 <= awvalid;
            arvalid_bf <= arvalid_s1;
            awvalid_bf <= awvalid_s1;
            mode_s1    <= mode;
            mode_s2    <= mode_s1;
        end
    end

    // bank outputs arrive with stage 1, so hits are captured one stage later
    always_ff @(posedge clk) begin
        arid_s1     <= arid;
        awid_s1     <= awid;
        ar_match_s1 <= ar_code_match;
        arid_bf     <= arid_s1;
        awid_bf     <= awid_s1;
        ar_match_s2 <= ar_match_s1;
        ar_hit_s2   <= ar_hit0 && ar_hit1;
        aw_hit_s2   <= aw_hit0 && aw_hit1;
    end

    assign ar_is_faulty = arvalid_bf
                          && (((mode_s2 == MODE_QUERY) && ar_hit_s2)
                              || ((mode_s2 == MODE_CODE_MATCH) && ar_match_s2));

    // writes stay on the filter in code match mode
    assign aw_is_faulty = awvalid_bf && aw_hit_s2
                          && ((mode_s2 == MODE_QUERY) || (mode_s2 == MODE_CODE_MATCH));

endmodule

/* hdl/bf_code_match.sv */
module bf_code_match (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              code_load,
    input  bf_pkg::cmd_word_t code_word,
    input  bf_pkg::addr_t     addr,
    output logic              match
);
    import bf_pkg::*;

    addr_t mask;
    addr_t code;
    logic  framed;

    assign framed = (code_word[CMD_W-1 -: MARK_W] == CODE_MARK_HI)
                    && (code_word[MARK_W-1:0] == CODE_MARK_LO);

    // unframed words leave the old code in place
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mask <= '0;
            code <= '0;
        end else if (code_load && framed) begin
            mask <= code_word[CODE_MASK_LSB +: ADDR_W];
            code <= code_word[CODE_CODE_LSB +: ADDR_W];
        end
    end

    assign match = ((addr & mask) == (code & mask));

endmodule

/* hdl/bf_bit_bank.sv */
module bf_bit_bank (
    input  logic               clk,
    input  logic               wr_en,
    input  logic               wr_bit,
    input  bf_pkg::bank_addr_t wr_addr,
    input  bf_pkg::bank_addr_t rd_addr_a,
    input  bf_pkg::bank_addr_t rd_addr_b,
    output logic               q_a,
    output logic               q_b
);
    import bf_pkg::*;

    logic mem [FILTER_SIZE];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_bit;
        end
    end

    // read before write on a collision
    always_ff @(posedge clk) begin
        q_a <= mem[rd_addr_a];
        q_b <= mem[rd_addr_b];
    end

endmodule

/* hdl/bf_hash.sv */
module bf_hash (
    input  bf_pkg::addr_t      key,
    output bf_pkg::bank_addr_t h0,
    output bf_pkg::bank_addr_t h1
);
    import bf_pkg::*;

    hash_word_t key_ext;
    hash_word_t h0_a;
    hash_word_t h0_b;
    hash_word_t h1_a;
    hash_word_t h1_b;

    assign key_ext = hash_word_t'(key);

    // hash 0, plain shift-xor
    assign h0_a = key_ext ^ (key_ext >> HASH0_SH_A);
    assign h0_b = h0_a ^ (h0_a >> HASH0_SH_B);

    // hash 1, seeded; first shift works on the unseeded key
    assign h1_a = (key_ext ^ HASH_SEED) ^ (key_ext >> HASH1_SH_A);
    assign h1_b = h1_a ^ (h1_a >> HASH1_SH_B);

    assign h0 = h0_b[FILTER_W-1:0];
    assign h1 = h1_b[FILTER_W-1:0];

endmodule

/* hdl/bf_cmd_ctrl.sv */
module bf_cmd_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              csr_req,
    input  bf_pkg::cmd_word_t csr_data,
    output logic              csr_ack,
    output bf_pkg::bf_mode_e  mode,
    output logic              wr_en,
    output logic              wr_bit,
    output bf_pkg::addr_t     wr_key,
    output logic              code_load,
    output bf_pkg::cmd_word_t code_word
);
    import bf_pkg::*;

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_ACK,
        HS_WAIT
    } hs_state_e;

    hs_state_e hs_state;
    hs_state_e hs_next;
    logic      take;
    logic      is_mode_word;
    bf_mode_e  new_mode;

    // a word is taken once, while ack is still low
    assign take    = csr_req && (hs_state == HS_IDLE);
    assign csr_ack = (hs_state != HS_IDLE);

    always_comb begin
        hs_next = hs_state;
        case (hs_state)
            HS_IDLE: begin
                if (csr_req) begin
                    hs_next = HS_ACK;
                end
            end
            HS_ACK: begin
                if (csr_req) begin
                    hs_next = HS_WAIT;
                end else begin
                    hs_next = HS_IDLE;
                end
            end
            HS_WAIT: begin
                if (!csr_req) begin
                    hs_next = HS_IDLE;
                end
            end
            default: hs_next = HS_IDLE;
        endcase
    end

    // mode word decode
    always_comb begin
        is_mode_word = 1'b1;
        new_mode     = mode;
        case (csr_data)
            CMD_IDLE:       new_mode = MODE_IDLE;
            CMD_INSERT:     new_mode = MODE_INSERT;
            CMD_REMOVE:     new_mode = MODE_REMOVE;
            CMD_QUERY:      new_mode = MODE_QUERY;
            CMD_CODE_LOAD:  new_mode = MODE_CODE_LOAD;
            CMD_CODE_MATCH: new_mode = MODE_CODE_MATCH;
            default:        is_mode_word = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_state  <= HS_IDLE;
            mode      <= MODE_IDLE;
            wr_en     <= 1'b0;
            code_load <= 1'b0;
        end else begin
            hs_state  <= hs_next;
            wr_en     <= take && !is_mode_word
                         && ((mode == MODE_INSERT) || (mode == MODE_REMOVE));
            code_load <= take && !is_mode_word && (mode == MODE_CODE_LOAD);
            if (take && is_mode_word) begin
                mode <= new_mode;
            end
        end
    end

    // data word payload, qualified by the strobes above
    always_ff @(posedge clk) begin
        if (take) begin
            wr_bit    <= (mode == MODE_INSERT);
            wr_key    <= csr_data[KEY_LSB +: ADDR_W];
            code_word <= csr_data;
        end
    end

endmodule

/* hdl/bf_pkg.sv */
package bf_pkg;

    // request side widths
    localparam int ADDR_W = 27;
    localparam int ID_W   = 8;
    localparam int CMD_W  = 64;

    // filter geometry
    localparam int FILTER_W    = 10;
    localparam int FILTER_SIZE = 1 << FILTER_W;
    localparam int NUM_BANKS   = 2;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [ID_W-1:0]     id_t;
    typedef logic [CMD_W-1:0]    cmd_word_t;
    typedef logic [FILTER_W-1:0] bank_addr_t;

    typedef enum logic [2:0] {
        MODE_IDLE       = 3'd0,
        MODE_INSERT     = 3'd1,
        MODE_REMOVE     = 3'd2,
        MODE_QUERY      = 3'd3,
        MODE_CODE_LOAD  = 3'd4,
        MODE_CODE_MATCH = 3'd5
    } bf_mode_e;

    // mode switch words
    localparam cmd_word_t CMD_IDLE       = 64'h7EA7BA0F2EA9BA08;
    localparam cmd_word_t CMD_INSERT     = 64'hAFE0D0FDBF0FAFC0;
    localparam cmd_word_t CMD_REMOVE     = 64'hAECF0EAFBEABBCBF;
    localparam cmd_word_t CMD_QUERY      = 64'hFEA0AFE0B0FFA0EF;
    localparam cmd_word_t CMD_CODE_LOAD  = 64'hF0E0FEA0BACFEFAC;
    localparam cmd_word_t CMD_CODE_MATCH = 64'hCEAFE0AC0FEF0AE0;

    // code load framing, marker at each end of the word
    localparam int          MARK_W        = 5;
    localparam logic [4:0]  CODE_MARK_HI  = 5'b01010;
    localparam logic [4:0]  CODE_MARK_LO  = 5'b10101;
    localparam int          CODE_MASK_LSB = 32;
    localparam int          CODE_CODE_LSB = 5;

    // insert/remove key position in a data word
    localparam int KEY_LSB = 0;

    // shift-xor hashes work on a 32 bit key
    localparam int HASH_W = 32;
    typedef logic [HASH_W-1:0] hash_word_t;

    localparam hash_word_t HASH_SEED = 32'h811c9dc5;
    localparam int HASH0_SH_A = 13;
    localparam int HASH0_SH_B = 7;
    localparam int HASH1_SH_A = 11;
    localparam int HASH1_SH_B = 3;

endpackage
